//--- bus_consts.svh
//////////////////////////////
// Bus widths, memory depth and AXI response codes
//////////////////////////////
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Bus widths
`define BUS_ADDR_BITS 32
`define BUS_DATA_BITS 32
`define BUS_STRB_BITS 4

// Slave memory depth in 32-bit words, byte addresses 0..255
`define MEM_WORDS 64

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

//--- bus_pkg.sv
//////////////////////////////
// Master FSM states, AXI response type,
// AXI4-Lite channel and CPU request structs
//////////////////////////////
`include "bus_consts.svh"

package bus_pkg;

  // Master walks AR->R for reads, AW->W->B for writes
  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW,
    W,
    B
  } master_state_t;

  typedef enum logic [1:0] {
    OKAY   = `RESP_OKAY,
    SLVERR = `RESP_SLVERR
  } axi_resp_t;

  // Write address channel
  typedef struct packed {
    logic [`BUS_ADDR_BITS-1:0] addr;
  } axi_aw_t;

  // Read address channel
  typedef struct packed {
    logic [`BUS_ADDR_BITS-1:0] addr;
  } axi_ar_t;

  // Write data channel
  typedef struct packed {
    logic [`BUS_DATA_BITS-1:0] data;
    logic [`BUS_STRB_BITS-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    logic [`BUS_DATA_BITS-1:0] data;
    axi_resp_t                 resp;
  } axi_r_t;

  // CPU side request, held stable while stall is high
  typedef struct packed {
    logic                      write;
    logic [`BUS_STRB_BITS-1:0] strb;
    logic [`BUS_DATA_BITS-1:0] wdata;
    logic [`BUS_ADDR_BITS-1:0] addr;
  } cpu_req_t;

endpackage

//--- axi_wait_counter.sv
//////////////////////////////
// Wait-state down-counter
//////////////////////////////
`timescale 1ns/1ps

module axi_wait_counter (
  input  logic       clk,
  input  logic       rstn,
  input  logic       start,
  input  logic [7:0] wait_cycles,
  output logic       busy,
  output logic       fire
);

  logic [7:0] cnt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt  <= 8'd0;
      busy <= 1'b0;
    end else if (start && (wait_cycles != 8'd0)) begin
      cnt  <= wait_cycles;
      busy <= 1'b1;
    end else if (busy) begin
      cnt <= cnt - 8'd1;
      // Last counting cycle
      if (cnt == 8'd1) begin
        busy <= 1'b0;
      end
    end
  end

  // Zero wait fires in the start cycle itself
  assign fire = (start && (wait_cycles == 8'd0)) || (busy && (cnt == 8'd1));

  a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
    start |-> !busy);

endmodule

//--- axi_master_fsm.sv
//////////////////////////////
// AXI4-Lite master FSM with CPU stall
//////////////////////////////
`timescale 1ns/1ps

module axi_master_fsm
  import bus_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  // CPU side
  input  logic access_request,
  input  logic write,
  // AXI handshake signals
  input  logic aw_ready,
  input  logic w_ready,
  input  logic b_valid,
  input  logic ar_ready,
  input  logic r_valid,
  output logic aw_valid,
  output logic w_valid,
  output logic b_ready,
  output logic ar_valid,
  output logic r_ready,
  output logic stall,
  // Capture pulses for the request registers
  output logic load_rd,
  output logic load_wr
);

  master_state_t state, next_state;
  master_state_t req_state;
  logic rd_req, wr_req;
  logic aw_hs, w_hs, b_hs, ar_hs, r_hs;

  assign wr_req = access_request & write;
  assign rd_req = access_request & ~write;

  // Where a new request starts from
  assign req_state = wr_req ? AW : (rd_req ? AR : IDLE);

  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;
  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // A finished access goes straight to the next request
  always_comb begin
    next_state = IDLE;
    case (state)
      IDLE: next_state = req_state;
      AR:   next_state = ar_hs ? R : AR;
      R:    next_state = r_hs ? req_state : R;
      AW:   next_state = aw_hs ? (w_hs ? B : W) : AW;
      W:    next_state = w_hs ? B : W;
      B:    next_state = b_hs ? req_state : B;
      default: next_state = IDLE;
    endcase
  end

  always_comb begin
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    stall    = 1'b0;
    case (state)
      IDLE: begin
        // Request seen but not yet issued
        stall = access_request;
      end
      AR: begin
        ar_valid = 1'b1;
        stall    = 1'b1;
      end
      R: begin
        r_ready = 1'b1;
        stall   = ~r_valid;
      end
      AW: begin
        aw_valid = 1'b1;
        w_valid  = aw_hs;
        stall    = 1'b1;
      end
      W: begin
        w_valid = 1'b1;
        b_ready = 1'b1;
        stall   = 1'b1;
      end
      B: begin
        b_ready = 1'b1;
        stall   = ~b_valid;
      end
      default: begin
        stall = 1'b0;
      end
    endcase
  end

  // Registers load on the edge that enters AR or AW
  assign load_rd = (state != AR) && (next_state == AR);
  assign load_wr = (state != AW) && (next_state == AW);

  // Address valids may not drop before their ready
  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    ar_valid && !ar_ready |=> ar_valid);

  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    aw_valid && !aw_ready |=> aw_valid);

endmodule

//--- axi_req_regs.sv
//////////////////////////////
// Request capture and read data / error hold
//////////////////////////////
`timescale 1ns/1ps
`include "bus_consts.svh"

module axi_req_regs
  import bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rstn,
  input  cpu_req_t                  req,
  input  logic                      load_rd,
  input  logic                      load_wr,
  input  axi_r_t                    r,
  input  logic                      r_valid,
  input  logic                      r_ready,
  input  axi_b_t                    b,
  input  logic                      b_valid,
  input  logic                      b_ready,
  output axi_aw_t                   aw,
  output axi_w_t                    w,
  output axi_ar_t                   ar,
  output logic [`BUS_DATA_BITS-1:0] data_out,
  output logic                      err
);

  logic                      r_hs, b_hs;
  logic [`BUS_DATA_BITS-1:0] rdata_q;
  logic                      err_q;

  assign r_hs = r_valid & r_ready;
  assign b_hs = b_valid & b_ready;

  // Channel payloads, stable for the whole access
  always_ff @(posedge clk) begin
    if (load_rd) begin
      ar.addr <= req.addr;
    end
    if (load_wr) begin
      aw.addr <= req.addr;
      w.data  <= req.wdata;
      w.strb  <= req.strb;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (r_hs) begin
      rdata_q <= r.data;
      err_q   <= (r.resp == SLVERR);
    end else if (b_hs) begin
      err_q <= (b.resp == SLVERR);
    end
  end

  // Bypass so the CPU sees the result in the handshake cycle
  assign data_out = r_hs ? r.data : rdata_q;
  assign err      = r_hs ? (r.resp == SLVERR) :
                    b_hs ? (b.resp == SLVERR) : err_q;

endmodule

//--- axi_lite_sram.sv
//////////////////////////////
// AXI4-Lite slave memory with byte strobes,
// wait states and SLVERR past the end
//////////////////////////////
`timescale 1ns/1ps
`include "bus_consts.svh"

module axi_lite_sram
  import bus_pkg::*;
#(
  parameter int WAIT_CYCLES = 2
) (
  input  logic    clk,
  input  logic    rstn,
  input  axi_aw_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  localparam int IDX_BITS = $clog2(`MEM_WORDS);
  localparam logic [7:0] WAIT_W = 8'(WAIT_CYCLES);

  logic [`BUS_DATA_BITS-1:0] mem [`MEM_WORDS];

  logic                      req_start, req_fire, req_busy, req_hold;
  logic                      rsp_fire;
  logic                      wr_sel_q, wr_sel, ready_win;
  logic                      wr_accept, ar_hs, r_hs, b_hs;
  logic                      outstanding;
  logic [`BUS_ADDR_BITS-1:0] rd_addr_q, rd_addr;
  logic                      wr_in_range, rd_in_range;

  assign r_hs = r_valid & r_ready;
  assign b_hs = b_valid & b_ready;

  // One request at a time, none while a response is owed
  assign req_start = (aw_valid | ar_valid) & ~req_busy & ~req_hold & ~outstanding;

  axi_wait_counter u_req_wait (
    .clk         (clk),
    .rstn        (rstn),
    .start       (req_start),
    .wait_cycles (WAIT_W),
    .busy        (req_busy),
    .fire        (req_fire)
  );

  // Writes win when both address channels are valid
  assign wr_sel    = req_start ? aw_valid : wr_sel_q;
  assign ready_win = req_fire | req_hold;
  assign aw_ready  = ready_win & wr_sel;
  assign w_ready   = ready_win & wr_sel;
  assign ar_ready  = ready_win & ~wr_sel;

  assign wr_accept = aw_valid & aw_ready & w_valid & w_ready;
  assign ar_hs     = ar_valid & ar_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_sel_q    <= 1'b0;
      req_hold    <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      if (req_start) begin
        wr_sel_q <= aw_valid;
      end
      // Keep ready up until the master completes the handshake
      if (wr_accept || ar_hs) begin
        req_hold <= 1'b0;
      end else if (req_fire) begin
        req_hold <= 1'b1;
      end
      if (wr_accept || ar_hs) begin
        outstanding <= 1'b1;
      end else if (r_hs || b_hs) begin
        outstanding <= 1'b0;
      end
    end
  end

  // Read response wait starts at the AR handshake
  axi_wait_counter u_rsp_wait (
    .clk         (clk),
    .rstn        (rstn),
    .start       (ar_hs),
    .wait_cycles (WAIT_W),
    .busy        (),
    .fire        (rsp_fire)
  );

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr_q <= ar.addr;
    end
  end

  assign rd_addr     = ar_hs ? ar.addr : rd_addr_q;
  assign rd_in_range = (rd_addr >> 2) < `MEM_WORDS;
  assign wr_in_range = (aw.addr >> 2) < `MEM_WORDS;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
      b_valid <= 1'b0;
      b.resp  <= OKAY;
      r_valid <= 1'b0;
      r.data  <= '0;
      r.resp  <= OKAY;
    end else begin
      // Out-of-range writes are dropped
      if (wr_accept && wr_in_range) begin
        for (int i = 0; i < `BUS_STRB_BITS; i++) begin
          if (w.strb[i]) begin
            mem[aw.addr[IDX_BITS+1:2]][8*i +: 8] <= w.data[8*i +: 8];
          end
        end
      end
      if (wr_accept) begin
        b_valid <= 1'b1;
        b.resp  <= wr_in_range ? OKAY : SLVERR;
      end else if (b_hs) begin
        b_valid <= 1'b0;
      end
      if (rsp_fire) begin
        r_valid <= 1'b1;
        r.data  <= rd_in_range ? mem[rd_addr[IDX_BITS+1:2]] : '0;
        r.resp  <= rd_in_range ? OKAY : SLVERR;
      end else if (r_hs) begin
        r_valid <= 1'b0;
      end
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

//--- cpu_axi_top.sv
//////////////////////////////
// CPU to AXI4-Lite bridge with slave memory
//////////////////////////////
`timescale 1ns/1ps
`include "bus_consts.svh"

module cpu_axi_top
  import bus_pkg::*;
#(
  parameter int WAIT_CYCLES = 2
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      access_request,
  input  cpu_req_t                  req,
  output logic [`BUS_DATA_BITS-1:0] data_out,
  output logic                      err,
  output logic                      stall
);

  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  axi_ar_t ar;
  axi_r_t  r;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic    ar_valid, ar_ready, r_valid, r_ready;
  logic    load_rd, load_wr;

  axi_master_fsm u_fsm (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .write          (req.write),
    .aw_ready       (aw_ready),
    .w_ready        (w_ready),
    .b_valid        (b_valid),
    .ar_ready       (ar_ready),
    .r_valid        (r_valid),
    .aw_valid       (aw_valid),
    .w_valid        (w_valid),
    .b_ready        (b_ready),
    .ar_valid       (ar_valid),
    .r_ready        (r_ready),
    .stall          (stall),
    .load_rd        (load_rd),
    .load_wr        (load_wr)
  );

  axi_req_regs u_regs (
    .clk      (clk),
    .rstn     (rstn),
    .req      (req),
    .load_rd  (load_rd),
    .load_wr  (load_wr),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .aw       (aw),
    .w        (w),
    .ar       (ar),
    .data_out (data_out),
    .err      (err)
  );

  axi_lite_sram #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_sram (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

endmodule

//--- tb_cpu_axi.sv
//////////////////////////////
// Testbench for the CPU to AXI4-Lite bridge
//////////////////////////////
`timescale 1ns/1ps
`include "bus_consts.svh"

module tb_cpu_axi
  import bus_pkg::*;
();

  localparam int WAIT_CYCLES    = 2;
  localparam int NUM_VEC        = 36;
  localparam int VEC_FIELDS     = 6;
  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 3;
  localparam int CYCLES_PER_VEC = 4 * WAIT_CYCLES + 10;

  logic                      clk;
  logic                      rstn;
  logic                      access_request;
  cpu_req_t                  req;
  logic [`BUS_DATA_BITS-1:0] data_out;
  logic                      err;
  logic                      stall;

  // Six words per access, see the data file
  logic [31:0] vec_mem [NUM_VEC*VEC_FIELDS];
  logic [31:0] model_mem [`MEM_WORDS];
  logic [31:0] last_rdata;
  int          error_count;
  int          check_count;
  int          cur_vec;
  integer      seed;

  cpu_axi_top #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_cpu_axi_top (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .req            (req),
    .data_out       (data_out),
    .err            (err),
    .stall          (stall)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #((NUM_VEC * CYCLES_PER_VEC + RESET_CYCLES + 10) * CLK_PERIOD);
    $display("Timeout: the accesses did not finish in the expected time (vector %0d)",
             cur_vec);
    $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got 0x%08h expected 0x%08h (vector %0d, %0t)",
               name, got, exp, cur_vec, $time);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic addr_mapped(input logic [31:0] addr);
    return addr < 4 * `MEM_WORDS;
  endfunction

  // Called on a falling edge, returns on the falling edge where stall is low
  task automatic run_access(input int idx);
    logic [31:0] op, addr, wdata, strb, exp_data, exp_err;
    logic [31:0] model_val;
    logic        mapped;
    int          cycles;
    op       = vec_mem[idx*VEC_FIELDS];
    addr     = vec_mem[idx*VEC_FIELDS+1];
    wdata    = vec_mem[idx*VEC_FIELDS+2];
    strb     = vec_mem[idx*VEC_FIELDS+3];
    exp_data = vec_mem[idx*VEC_FIELDS+4];
    exp_err  = vec_mem[idx*VEC_FIELDS+5];
    mapped   = addr_mapped(addr);
    cur_vec  = idx;
    access_request = 1'b1;
    req.write      = op[0];
    req.addr       = addr;
    req.wdata      = wdata;
    req.strb       = strb[3:0];
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (stall && cycles < CYCLES_PER_VEC);
    if (stall) begin
      error_count++;
      $display("Access %0d did not complete within %0d cycles", idx, CYCLES_PER_VEC);
      return;
    end
    if (op[0]) begin
      check_val("err", err, exp_err);
      check_val("err", err, {31'b0, !mapped});
      // Read data register is untouched by writes
      check_val("data_out", data_out, last_rdata);
      if (mapped) begin
        model_mem[addr >> 2] = merge_bytes(model_mem[addr >> 2], wdata, strb[3:0]);
      end
    end else begin
      model_val = mapped ? model_mem[addr >> 2] : 32'h0;
      check_val("data_out", data_out, exp_data);
      check_val("data_out", data_out, model_val);
      check_val("err", err, exp_err);
      check_val("err", err, {31'b0, !mapped});
      last_rdata = model_val;
    end
  endtask

  initial begin
    int          gap;
    logic [31:0] op;
    seed           = 32'h4898;
    error_count    = 0;
    check_count    = 0;
    cur_vec        = -1;
    last_rdata     = 32'h0;
    rstn           = 1'b0;
    access_request = 1'b0;
    req            = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = 32'h0;
    end
    $readmemh("cpu_axi_testdata.hex", vec_mem);
    if ($isunknown(vec_mem[NUM_VEC*VEC_FIELDS-1])) begin
      error_count++;
      $display("The test data file is missing or has too few vectors");
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_val("stall", stall, 32'h0);
    check_val("err", err, 32'h0);
    check_val("data_out", data_out, 32'h0);

    for (int i = 0; i < NUM_VEC; i++) begin
      op  = vec_mem[i*VEC_FIELDS];
      gap = $unsigned($random(seed)) % 4;
      // op bit 1 keeps access_request high from the previous access
      if (op[1]) begin
        gap = 0;
      end
      if (gap > 0) begin
        access_request = 1'b0;
        repeat (gap) @(negedge clk);
        check_val("stall", stall, 32'h0);
      end
      run_access(i);
    end

    access_request = 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_val("stall", stall, 32'h0);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- cpu_axi_testdata.hex
// op addr wdata strb exp_data exp_err, op bit0 = write, bit1 = no idle gap before
// exp_data is checked on reads only, writes check the held read data
0 00000000 00000000 0 00000000 0
1 00000010 DEADBEEF F 00000000 0
0 00000010 00000000 0 DEADBEEF 0
1 00000020 11223344 F 00000000 0
1 00000020 AABBCCDD 3 00000000 0
0 00000020 00000000 0 1122CCDD 0
1 00000024 55667788 F 00000000 0
1 00000024 99AABBCC C 00000000 0
0 00000024 00000000 0 99AA7788 0
1 00000028 CAFEF00D 1 00000000 0
2 00000028 00000000 0 0000000D 0
3 0000002C 0BADC0DE F 00000000 0
2 0000002C 00000000 0 0BADC0DE 0
3 00000030 12345678 F 00000000 0
3 00000034 87654321 F 00000000 0
2 00000030 00000000 0 12345678 0
2 00000034 00000000 0 87654321 0
0 00000100 00000000 0 00000000 1
1 00000100 FFFFFFFF F 00000000 1
0 00000000 00000000 0 00000000 0
1 00000110 FFFFFFFF F 00000000 1
0 00000010 00000000 0 DEADBEEF 0
2 FFFFFFFC 00000000 0 00000000 1
3 000000FC A5A5A5A5 F 00000000 0
2 000000FC 00000000 0 A5A5A5A5 0
1 00000040 F0E1D2C3 F 00000000 0
1 00000040 00FF00FF 5 00000000 0
0 00000040 00000000 0 F0FFD2FF 0
3 00000040 12345678 0 00000000 0
2 00000040 00000000 0 F0FFD2FF 0
1 000000FC 5A000000 8 00000000 0
0 000000FC 00000000 0 5AA5A5A5 0
2 00000020 00000000 0 1122CCDD 0
2 00000024 00000000 0 99AA7788 0
2 00000200 00000000 0 00000000 1
2 00000010 00000000 0 DEADBEEF 0

//--- tb.f
+incdir+.
bus_pkg.sv
axi_wait_counter.sv
axi_master_fsm.sv
axi_req_regs.sv
axi_lite_sram.sv
cpu_axi_top.sv
tb_cpu_axi.sv
